// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address split: tag | index | offset
    parameter int index_w  = 6;
    parameter int tag_w    = 23;
    parameter int offset_w = 3;

    // one line holds two words
    parameter int line_w = 64;
    parameter int word_w = 32;
    parameter int sets   = 64;

    typedef enum logic [1:0] {
        idle   = 2'd0,
        lookup = 2'd1,
        miss   = 2'd2,
        refill = 2'd3
    } cache_state_e;

    // processor request, a byte address in tag/index/offset form
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } cpu_req_t;

    // one valid/tag table entry
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } vtag_t;

    // line write into one way
    typedef struct packed {
        logic               we;
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
        logic [line_w-1:0]  line;
    } way_fill_t;

endpackage

`default_nettype wire

// File: rtl/icache_way.sv
`default_nettype none

module icache_way (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rd_en,
    input  logic [icache_pkg::index_w-1:0]    rd_index,
    input  logic [icache_pkg::tag_w-1:0]      cmp_tag,
    input  icache_pkg::way_fill_t             fill,
    output icache_pkg::vtag_t                 entry,
    output logic [icache_pkg::line_w-1:0]     line,
    output logic                              hit
);

    // valid bits sit in flops so reset can clear them all at once
    logic [icache_pkg::sets-1:0] valid_q;

    logic [icache_pkg::tag_w-1:0]  tag_mem  [icache_pkg::sets];
    logic [icache_pkg::line_w-1:0] data_mem [icache_pkg::sets];

    // registered read side
    logic                          rd_valid;
    logic [icache_pkg::tag_w-1:0]  rd_tag;
    logic [icache_pkg::line_w-1:0] rd_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill.we) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (rd_en) begin
            rd_valid <= valid_q[rd_index];
        end
    end

    // tag and data arrays, synchronous read and write
    always_ff @(posedge clk) begin
        if (fill.we) begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.line;
        end
        if (rd_en) begin
            rd_tag  <= tag_mem[rd_index];
            rd_line <= data_mem[rd_index];
        end
    end

    assign entry.valid = rd_valid;
    assign entry.tag   = rd_tag;
    assign line        = rd_line;

    // local compare against the buffered request tag
    assign hit = rd_valid && (rd_tag == cmp_tag);

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    // processor side
    input  logic                              valid,
    input  icache_pkg::cpu_req_t              req,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [icache_pkg::word_w-1:0]     rdata,
    // memory side
    output logic                              rd_req,
    output logic [31:0]                       rd_addr,
    input  logic [icache_pkg::line_w-1:0]     ret_data,
    // way results
    input  icache_pkg::vtag_t                 way0_entry,
    input  icache_pkg::vtag_t                 way1_entry,
    input  logic [icache_pkg::line_w-1:0]     way0_line,
    input  logic [icache_pkg::line_w-1:0]     way1_line,
    input  logic                              way0_hit,
    input  logic                              way1_hit,
    // way control
    output logic                              rd_en,
    output logic [icache_pkg::index_w-1:0]    rd_index,
    output logic [icache_pkg::tag_w-1:0]      cmp_tag,
    output icache_pkg::way_fill_t             fill0,
    output icache_pkg::way_fill_t             fill1
);

    icache_pkg::cache_state_e state;
    icache_pkg::cache_state_e next_state;

    icache_pkg::cpu_req_t          req_q;
    logic [icache_pkg::line_w-1:0] refill_q;
    logic                          toggle;
    logic                          victim;
    logic                          victim_pick;
    logic                          cache_hit;
    logic                          accept;
    logic [icache_pkg::line_w-1:0] hit_line;
    logic [icache_pkg::word_w-1:0] hit_word;
    logic [icache_pkg::word_w-1:0] refill_word;

    assign cache_hit = way0_hit || way1_hit;

    // acceptance handshake
    assign addr_ok = (state == icache_pkg::idle) ||
                     ((state == icache_pkg::lookup) && cache_hit);
    assign accept  = valid && addr_ok;

    always_comb begin
        case (state)
            icache_pkg::idle: begin
                next_state = valid ? icache_pkg::lookup : icache_pkg::idle;
            end
            icache_pkg::lookup: begin
                if (cache_hit) begin
                    next_state = valid ? icache_pkg::lookup : icache_pkg::idle;
                end else begin
                    next_state = icache_pkg::miss;
                end
            end
            icache_pkg::miss: begin
                next_state = icache_pkg::refill;
            end
            icache_pkg::refill: begin
                next_state = icache_pkg::idle;
            end
            default: begin
                next_state = icache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // the ways read in the same edge that accepts the request
    assign rd_en    = accept;
    assign rd_index = req.index;
    assign cmp_tag  = req_q.tag;

    // free-running replacement toggle
    always_ff @(posedge clk) begin
        if (rst) begin
            toggle <= 1'b0;
        end else begin
            toggle <= ~toggle;
        end
    end

    // empty way first, way0 before way1
    always_comb begin
        if (!way0_entry.valid) begin
            victim_pick = 1'b0;
        end else if (!way1_entry.valid) begin
            victim_pick = 1'b1;
        end else begin
            victim_pick = toggle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= 1'b0;
        end else if ((state == icache_pkg::lookup) && !cache_hit) begin
            victim <= victim_pick;
        end
    end

    // memory answers in the same cycle as rd_req
    always_ff @(posedge clk) begin
        if (state == icache_pkg::miss) begin
            refill_q <= ret_data;
        end
    end

    assign rd_req  = (state == icache_pkg::miss);
    assign rd_addr = {req_q.tag, req_q.index, {icache_pkg::offset_w{1'b0}}};

    // line write in refill, victim way only
    always_comb begin
        fill0.we    = (state == icache_pkg::refill) && !victim;
        fill0.index = req_q.index;
        fill0.tag   = req_q.tag;
        fill0.line  = refill_q;
        fill1       = fill0;
        fill1.we    = (state == icache_pkg::refill) && victim;
    end

    // word select, offset bit 2 picks the upper word
    assign hit_line = way0_hit ? way0_line : way1_line;
    assign hit_word = req_q.offset[2] ? hit_line[icache_pkg::word_w +: icache_pkg::word_w]
                                      : hit_line[0 +: icache_pkg::word_w];
    assign refill_word = req_q.offset[2] ? refill_q[icache_pkg::word_w +: icache_pkg::word_w]
                                         : refill_q[0 +: icache_pkg::word_w];

    assign data_ok = ((state == icache_pkg::lookup) && cache_hit) ||
                     (state == icache_pkg::refill);
    assign rdata   = (state == icache_pkg::refill) ? refill_word : hit_word;

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`default_nettype none

module icache_top (
    input  logic                              clk,
    input  logic                              rst,
    // processor front end
    input  logic                              valid,
    input  icache_pkg::cpu_req_t              req,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [icache_pkg::word_w-1:0]     rdata,
    // next memory level
    output logic                              rd_req,
    output logic [31:0]                       rd_addr,
    input  logic [icache_pkg::line_w-1:0]     ret_data
);

    // shared read port of both ways
    logic                           rd_en;
    logic [icache_pkg::index_w-1:0] rd_index;
    logic [icache_pkg::tag_w-1:0]   cmp_tag;

    icache_pkg::way_fill_t          fill0;
    icache_pkg::way_fill_t          fill1;
    icache_pkg::vtag_t              way0_entry;
    icache_pkg::vtag_t              way1_entry;
    logic [icache_pkg::line_w-1:0]  way0_line;
    logic [icache_pkg::line_w-1:0]  way1_line;
    logic                           way0_hit;
    logic                           way1_hit;

    icache_way way0_inst (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .cmp_tag  (cmp_tag),
        .fill     (fill0),
        .entry    (way0_entry),
        .line     (way0_line),
        .hit      (way0_hit)
    );

    icache_way way1_inst (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .cmp_tag  (cmp_tag),
        .fill     (fill1),
        .entry    (way1_entry),
        .line     (way1_line),
        .hit      (way1_hit)
    );

    icache_ctrl ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .ret_data   (ret_data),
        .way0_entry (way0_entry),
        .way1_entry (way1_entry),
        .way0_line  (way0_line),
        .way1_line  (way1_line),
        .way0_hit   (way0_hit),
        .way1_hit   (way1_hit),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .cmp_tag    (cmp_tag),
        .fill0      (fill0),
        .fill1      (fill1)
    );

endmodule

`default_nettype wire

// File: tb/icache_checker.sv
`default_nettype none

module icache_checker (
    input logic                     clk,
    input logic                     rst,
    input icache_pkg::cache_state_e state,
    input logic                     cache_hit,
    input logic                     addr_ok,
    input logic                     data_ok,
    input logic                     rd_req
);

    // failed assertions, read back by the testbench top
    int fails = 0;

    // both handshakes together only when a hit overlaps the next acceptance
    handshake_overlap: assert property (@(posedge clk) disable iff (rst)
        (data_ok && addr_ok) |-> ((state == icache_pkg::lookup) && cache_hit))
    else begin
        fails++;
        $error("data_ok and addr_ok both high outside a lookup hit");
    end

    // single-cycle line read, refill right after
    read_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_req |=> (!rd_req && (state == icache_pkg::refill)))
    else begin
        fails++;
        $error("rd_req not a single pulse followed by refill");
    end

    legal_state: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) &&
        ((state == icache_pkg::idle) || (state == icache_pkg::lookup) ||
         (state == icache_pkg::miss) || (state == icache_pkg::refill)))
    else begin
        fails++;
        $error("controller state is not a legal value");
    end

endmodule

`default_nettype wire

// File: tb/icache_scoreboard.sv
`default_nettype none

module icache_scoreboard (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic                          addr_ok,
    input  logic                          data_ok,
    input  logic [icache_pkg::word_w-1:0] rdata,
    input  logic                          rd_req,
    input  logic [31:0]                   rd_addr,
    // expected values that travel with the current request
    input  logic [icache_pkg::word_w-1:0] exp_word,
    input  logic [31:0]                   exp_line,
    output int                            pending,
    output int                            errors
);

    // one entry per accepted request, oldest first
    logic [31:0] word_q [$];
    logic [31:0] line_q [$];
    int          accept_q [$];

    int          cycle;
    logic [31:0] want_word;
    logic [31:0] drop_line;
    int          issued;
    int          last_accept;

    string test_name;
    int    test_num;
    int    exp_misses;
    bit    check_latency;
    int    test_reqs;
    int    test_misses;
    int    test_errs;
    int    tests_failed;
    int    checks;

    initial begin
        cycle = 0;
        pending = 0;
        errors = 0;
        test_num = 0;
        tests_failed = 0;
        checks = 0;
        exp_misses = -1;
        check_latency = 1'b0;
        last_accept = 0;
    end

    task record_error();
        errors++;
        test_errs++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycle = cycle + 1;
            if (rd_req) begin
                test_misses++;
                if (line_q.size() == 0) begin
                    record_error();
                    $display("rd_req issued with no request outstanding");
                end else begin
                    checks++;
                    if (rd_addr !== line_q[0]) begin
                        record_error();
                        $display("** Error: rd_addr got %h expected %h", rd_addr, line_q[0]);
                    end
                end
            end
            // the returned word belongs to an older request, so pop before push
            if (data_ok) begin
                if (word_q.size() == 0) begin
                    record_error();
                    $display("data_ok seen with no request outstanding");
                end else begin
                    want_word = word_q.pop_front();
                    drop_line = line_q.pop_front();
                    issued = accept_q.pop_front();
                    checks++;
                    if (rdata !== want_word) begin
                        record_error();
                        $display("** Error: rdata got %h expected %h", rdata, want_word);
                    end
                    if (check_latency && (cycle - issued != 1)) begin
                        record_error();
                        $display("data_ok came %0d cycles after acceptance instead of 1",
                                 cycle - issued);
                    end
                end
            end
            if (valid && addr_ok) begin
                // hits stream, so each request after the first is taken one cycle later
                if (check_latency && (test_reqs > 0) && (cycle - last_accept != 1)) begin
                    record_error();
                    $display("request accepted %0d cycles after the previous one instead of 1",
                             cycle - last_accept);
                end
                last_accept = cycle;
                word_q.push_back(exp_word);
                line_q.push_back(exp_line);
                accept_q.push_back(cycle);
                test_reqs++;
            end
            pending = word_q.size();
        end
    end

    // negative miss count means misses are not checked
    task open_test(input string name, input int misses, input bit latency);
        test_num++;
        test_name = name;
        exp_misses = misses;
        check_latency = latency;
        test_reqs = 0;
        test_misses = 0;
        test_errs = 0;
    endtask

    task close_test();
        if ((exp_misses >= 0) && (test_misses != exp_misses)) begin
            record_error();
            $display("%0d line reads in this test where %0d were expected",
                     test_misses, exp_misses);
        end
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d requests, %0d misses, %0d errors",
                 test_num, test_name, test_reqs, test_misses, test_errs);
    endtask

    task report();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_num, tests_failed, checks, errors);
    endtask

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
`default_nettype none

module icache_tb;

    localparam int total_reqs  = 8 + 16 + 4 + 16 + 300;
    localparam int cycle_limit = total_reqs * 6 + 200;

    logic                          clk;
    logic                          rst;
    logic                          valid;
    icache_pkg::cpu_req_t          req;
    logic                          addr_ok;
    logic                          data_ok;
    logic [icache_pkg::word_w-1:0] rdata;
    logic                          rd_req;
    logic [31:0]                   rd_addr;
    logic [icache_pkg::line_w-1:0] ret_data;

    logic [31:0]          exp_word;
    logic [31:0]          exp_line;
    int                   pending;
    int                   sb_errors;
    int                   cycles;
    int                   seed_val;
    icache_pkg::cpu_req_t lines [8];

    // memory contents: a scramble of the word address
    function automatic logic [31:0] mem_word(input logic [29:0] word_addr);
        return ({2'b00, word_addr} * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [63:0] mem_line(input logic [31:0] line_addr);
        return {mem_word(line_addr[31:2] + 30'd1), mem_word(line_addr[31:2])};
    endfunction

    function automatic logic [31:0] ref_word(input icache_pkg::cpu_req_t r);
        return mem_word({r.tag, r.index, r.offset[2]});
    endfunction

    function automatic logic [31:0] ref_line_addr(input icache_pkg::cpu_req_t r);
        return {r.tag, r.index, 3'b000};
    endfunction

    // next level answers in the same cycle
    assign ret_data = mem_line(rd_addr);

    icache_top icache_top_inst (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .req      (req),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    icache_scoreboard scoreboard_inst (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .exp_word (exp_word),
        .exp_line (exp_line),
        .pending  (pending),
        .errors   (sb_errors)
    );

    bind icache_ctrl icache_checker ctrl_checker_inst (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .cache_hit (cache_hit),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rd_req    (rd_req)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // called 2 units after a rising edge, returns likewise
    task send_request(input icache_pkg::cpu_req_t r);
        valid = 1'b1;
        req = r;
        exp_word = ref_word(r);
        exp_line = ref_line_addr(r);
        do begin
            @(negedge clk);
        end while (!addr_ok);
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    task wait_drained();
        do begin
            @(negedge clk);
        end while (pending != 0);
        @(posedge clk);
        #2;
    endtask

    initial begin
        icache_pkg::cpu_req_t r;
        icache_pkg::cpu_req_t a;
        icache_pkg::cpu_req_t b;
        logic [31:0]          v;
        int                   total;

        seed_val = $urandom(32'ha3a9);
        rst = 1'b1;
        valid = 1'b0;
        req = '0;
        exp_word = '0;
        exp_line = '0;

        // eight lines in distinct sets
        for (int i = 0; i < 8; i++) begin
            v = 32'h40 + 32'h111 * i;
            lines[i].tag = v[22:0];
            lines[i].index = 6'd1 + 6'd5 * i[5:0];
            lines[i].offset = 3'd0;
        end

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        scoreboard_inst.open_test("cold misses", 8, 1'b0);
        for (int i = 0; i < 8; i++) begin
            send_request(lines[i]);
        end
        wait_drained();
        scoreboard_inst.close_test();

        scoreboard_inst.open_test("hits after fill", 0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            send_request(lines[i]);
            r = lines[i];
            r.offset = 3'd4;
            send_request(r);
        end
        wait_drained();
        scoreboard_inst.close_test();

        // set 50 is not used by the lines above
        a.tag = 23'h0a5a5;
        a.index = 6'd50;
        a.offset = 3'd0;
        b = a;
        b.tag = 23'h1b6b6;
        scoreboard_inst.open_test("two tags in one set", 2, 1'b0);
        send_request(a);
        send_request(b);
        a.offset = 3'd4;
        send_request(a);
        send_request(b);
        wait_drained();
        scoreboard_inst.close_test();

        scoreboard_inst.open_test("back-to-back hits", 0, 1'b1);
        for (int k = 0; k < 16; k++) begin
            r = lines[k % 8];
            r.offset = {k[3], 2'b00};
            send_request(r);
        end
        wait_drained();
        scoreboard_inst.close_test();

        // four tags over all sets, with an idle cycle now and then
        scoreboard_inst.open_test("random stream", -1, 1'b0);
        repeat (300) begin
            v = $urandom;
            r.tag = {21'd0, v[7:6]};
            r.index = v[5:0];
            r.offset = {v[8], 2'b00};
            send_request(r);
            if (v[10:9] == 2'd0) begin
                @(posedge clk);
                #2;
            end
        end
        wait_drained();
        scoreboard_inst.close_test();

        scoreboard_inst.report();
        total = sb_errors + icache_top_inst.ctrl_inst.ctrl_checker_inst.fails;
        if ((total == 0) && (pending == 0)) begin
            $display("TEST OK");
        end else begin
            $display("assertion failures %0d",
                     icache_top_inst.ctrl_inst.ctrl_checker_inst.fails);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/icache_pkg.sv
rtl/icache_way.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_checker.sv
tb/icache_scoreboard.sv
tb/icache_tb.sv
